// File: hw/blur_pkg.sv
`default_nettype none

package blur_pkg;

    // ====================
    // widths
    // ====================
    typedef logic [31:0] t_line_addr;
    typedef logic [63:0] t_line_data;
    typedef logic [7:0]  t_pixel;
    // low 16 bits of the line index
    typedef logic [15:0] t_line_tag;
    typedef logic [31:0] t_count;
    typedef logic [3:0]  t_csr_addr;
    typedef logic [63:0] t_csr_data;

    typedef enum logic [1:0]
    {
        RUN_IDLE,
        RUN_ACTIVE,
        RUN_REPORT
    } t_run_state;

    // ====================
    // register map
    // ====================
    // read/write
    localparam t_csr_addr CSR_STATUS_ADDR = 4'd0;
    localparam t_csr_addr CSR_SRC_ADDR    = 4'd1;
    localparam t_csr_addr CSR_DST_ADDR    = 4'd2;
    localparam t_csr_addr CSR_NUM_LINES   = 4'd3;
    // read only
    localparam t_csr_addr CSR_READ_IDX    = 4'd4;
    localparam t_csr_addr CSR_WR_REQ_CNT  = 4'd5;
    localparam t_csr_addr CSR_WR_RSP_CNT  = 4'd6;
    localparam t_csr_addr CSR_STATE       = 4'd7;
    localparam t_csr_addr CSR_CYCLE_CNT   = 4'd8;
    // write only, bit 0 starts a run
    localparam t_csr_addr CSR_CTL         = 4'd10;

    // ====================
    // limits
    // ====================
    localparam int FIFO_DEPTH      = 32;
    localparam int FIFO_ALM_FULL   = 24;
    localparam int MAX_OUTSTANDING = 12;
    localparam int PIXELS_PER_LINE = 8;

endpackage

`default_nettype wire

// File: hw/wr_line_if.sv
`timescale 1ns/10ps
`default_nettype none

// one filtered line and its destination, strobed once per line
interface wr_line_if;
    import blur_pkg::*;

    logic       valid;
    t_line_addr addr;
    t_line_data data;
    // level from the receiving side, no strobes while high
    logic       stall;

    modport source
    (
        output valid,
        output addr,
        output data,
        input  stall
    );

    modport sink
    (
        input  valid,
        input  addr,
        input  data,
        output stall
    );

endinterface

`default_nettype wire

// File: hw/gaussian_row_filter.sv
`timescale 1ns/10ps
`default_nettype none

module gaussian_row_filter
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 in_valid,
    input  blur_pkg::t_line_data in_data,
    output logic                 out_valid,
    output blur_pkg::t_line_data out_data
);
    import blur_pkg::*;

    // row with the edge pixels repeated on both ends
    t_pixel     ext   [PIXELS_PER_LINE + 2];
    // 4 * 255 + 2 fits in ten bits
    logic [9:0] sum_d [PIXELS_PER_LINE];
    logic [9:0] sum_q [PIXELS_PER_LINE];
    logic       valid_q;

    always_comb
    begin
        ext[0]                   = in_data[7:0];
        ext[PIXELS_PER_LINE + 1] = in_data[8 * PIXELS_PER_LINE - 1 -: 8];
        for (int i = 0; i < PIXELS_PER_LINE; i++)
            ext[i + 1] = in_data[8 * i +: 8];
        // 1-2-1 kernel plus rounding
        for (int i = 0; i < PIXELS_PER_LINE; i++)
            sum_d[i] = {2'b00, ext[i]} + {1'b0, ext[i + 1], 1'b0}
                       + {2'b00, ext[i + 2]} + 10'd2;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            valid_q   <= 1'b0;
            out_valid <= 1'b0;
        end
        else
        begin
            valid_q   <= in_valid;
            out_valid <= valid_q;
        end
    end

    always_ff @(posedge clk)
    begin
        sum_q <= sum_d;
        for (int i = 0; i < PIXELS_PER_LINE; i++)
            out_data[8 * i +: 8] <= sum_q[i][9:2];
    end

endmodule

`default_nettype wire

// File: hw/afu_control.sv
`timescale 1ns/10ps
`default_nettype none

module afu_control
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 csr_wr_en,
    input  blur_pkg::t_csr_addr  csr_addr,
    input  blur_pkg::t_csr_data  csr_wr_data,
    output blur_pkg::t_csr_data  csr_rd_data,
    input  blur_pkg::t_count     read_idx,
    input  logic                 read_done,
    input  blur_pkg::t_count     wr_req_cnt,
    input  blur_pkg::t_count     wr_rsp_cnt,
    output logic                 run_active,
    output logic                 report,
    output blur_pkg::t_line_addr src_base,
    output blur_pkg::t_line_addr dst_base,
    output blur_pkg::t_line_addr status_addr,
    output blur_pkg::t_count     num_lines,
    output blur_pkg::t_count     cycle_cnt
);
    import blur_pkg::*;

    t_run_state state;
    logic       start_q;
    logic       ctl_wr;

    assign ctl_wr     = csr_wr_en && (csr_addr == CSR_CTL);
    assign run_active = (state == RUN_ACTIVE);
    // REPORT lasts a single cycle, so this is a pulse
    assign report     = (state == RUN_REPORT);

    // ====================
    // register writes
    // ====================
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            status_addr <= '0;
            src_base    <= '0;
            dst_base    <= '0;
            num_lines   <= '0;
            start_q     <= 1'b0;
        end
        else
        begin
            if (csr_wr_en && csr_addr == CSR_STATUS_ADDR)
                status_addr <= t_line_addr'(csr_wr_data);
            if (csr_wr_en && csr_addr == CSR_SRC_ADDR)
                src_base <= t_line_addr'(csr_wr_data);
            if (csr_wr_en && csr_addr == CSR_DST_ADDR)
                dst_base <= t_line_addr'(csr_wr_data);
            if (csr_wr_en && csr_addr == CSR_NUM_LINES)
                num_lines <= t_count'(csr_wr_data);
            // a start needs both bases and a line count
            start_q <= ctl_wr && csr_wr_data[0] && (src_base != '0)
                       && (dst_base != '0) && (num_lines != '0);
        end
    end

    // ====================
    // run state machine
    // ====================
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state     <= RUN_IDLE;
            cycle_cnt <= '0;
        end
        else
        begin
            case (state)
                RUN_IDLE:
                begin
                    if (start_q)
                    begin
                        state     <= RUN_ACTIVE;
                        cycle_cnt <= '0;
                    end
                end
                RUN_ACTIVE:
                begin
                    cycle_cnt <= cycle_cnt + 1;
                    // every line read and every write acknowledged
                    if (read_done && wr_rsp_cnt == num_lines)
                        state <= RUN_REPORT;
                end
                default:
                    state <= RUN_IDLE;
            endcase
        end
    end

    // register reads
    always_comb
    begin
        csr_rd_data = '0;
        case (csr_addr)
            CSR_STATUS_ADDR: csr_rd_data = t_csr_data'(status_addr);
            CSR_SRC_ADDR:    csr_rd_data = t_csr_data'(src_base);
            CSR_DST_ADDR:    csr_rd_data = t_csr_data'(dst_base);
            CSR_NUM_LINES:   csr_rd_data = t_csr_data'(num_lines);
            CSR_READ_IDX:    csr_rd_data = t_csr_data'(read_idx);
            CSR_WR_REQ_CNT:  csr_rd_data = t_csr_data'(wr_req_cnt);
            CSR_WR_RSP_CNT:  csr_rd_data = t_csr_data'(wr_rsp_cnt);
            CSR_STATE:
            begin
                csr_rd_data[1:0] = state;
                csr_rd_data[8]   = read_done;
            end
            CSR_CYCLE_CNT:   csr_rd_data = t_csr_data'(cycle_cnt);
            default:         csr_rd_data = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: hw/line_reader.sv
`timescale 1ns/10ps
`default_nettype none

module line_reader
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 run_active,
    input  blur_pkg::t_line_addr src_base,
    input  blur_pkg::t_line_addr dst_base,
    input  blur_pkg::t_count     num_lines,
    input  logic                 wr_rsp_valid,
    input  logic                 rd_almost_full,
    input  logic                 wr_almost_full,
    output logic                 rd_req_valid,
    output blur_pkg::t_line_addr rd_req_addr,
    output blur_pkg::t_line_tag  rd_req_tag,
    input  logic                 rd_rsp_valid,
    input  blur_pkg::t_line_tag  rd_rsp_tag,
    input  blur_pkg::t_line_data rd_rsp_data,
    output blur_pkg::t_count     read_idx,
    output logic                 read_done,
    wr_line_if.source            push
);
    import blur_pkg::*;

    logic       run_active_q;
    logic       can_read;
    logic       read_stage_2;
    logic       pace_ok;
    logic       issue;
    // lines read but not yet acknowledged as written
    t_count     outstanding;
    t_count     req_idx;
    t_line_addr rsp_addr_q;
    t_line_addr rsp_addr_qq;
    logic       filt_valid;
    t_line_data filt_data;

    assign read_done = (read_idx == num_lines);
    assign pace_ok   = !rd_almost_full && !wr_almost_full && !push.stall
                       && (outstanding < t_count'(MAX_OUTSTANDING));
    // pacing is checked again at stage two so a late almost-full still holds the read
    assign issue     = can_read && pace_ok && !read_done;

    // ====================
    // read issue
    // ====================
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            run_active_q <= 1'b0;
            can_read     <= 1'b0;
            read_stage_2 <= 1'b0;
            rd_req_valid <= 1'b0;
            read_idx     <= '0;
            outstanding  <= '0;
        end
        else
        begin
            run_active_q <= run_active;
            if (!run_active)
            begin
                can_read     <= 1'b0;
                read_stage_2 <= 1'b0;
                rd_req_valid <= 1'b0;
            end
            else if (!run_active_q)
            begin
                // first active cycle, start again at line zero
                read_idx    <= '0;
                outstanding <= '0;
                can_read    <= pace_ok;
            end
            else
            begin
                can_read     <= pace_ok;
                read_stage_2 <= issue;
                rd_req_valid <= read_stage_2;
                if (issue)
                    read_idx <= read_idx + 1;
                case ({issue, wr_rsp_valid})
                    2'b10:   outstanding <= outstanding + 1;
                    2'b01:   outstanding <= outstanding - 1;
                    default: outstanding <= outstanding;
                endcase
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (issue)
            req_idx <= read_idx;
        if (read_stage_2)
        begin
            rd_req_addr <= src_base + req_idx;
            rd_req_tag  <= t_line_tag'(req_idx);
        end
        // destination follows the filter through its two stages
        rsp_addr_q  <= dst_base + t_line_addr'(rd_rsp_tag);
        rsp_addr_qq <= rsp_addr_q;
    end

    gaussian_row_filter u_filter
    (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (rd_rsp_valid),
        .in_data   (rd_rsp_data),
        .out_valid (filt_valid),
        .out_data  (filt_data)
    );

    assign push.valid = filt_valid;
    assign push.addr  = rsp_addr_qq;
    assign push.data  = filt_data;

endmodule

`default_nettype wire

// File: hw/write_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module write_fifo
(
    input  logic      clk,
    input  logic      reset,
    wr_line_if.sink   push,
    wr_line_if.source pop
);
    import blur_pkg::*;

    localparam int PTR_W = $clog2(FIFO_DEPTH);

    t_line_addr       addr_mem [FIFO_DEPTH];
    t_line_data       data_mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             pop_stall_q;
    logic             do_push;
    logic             do_pop;

    assign do_push    = push.valid && (count != (PTR_W + 1)'(FIFO_DEPTH));
    // the writer adds a register, so the host port must be clear for two cycles
    assign do_pop     = (count != '0) && !pop.stall && !pop_stall_q;
    assign push.stall = (count >= (PTR_W + 1)'(FIFO_ALM_FULL));

    assign pop.valid = do_pop;
    assign pop.addr  = addr_mem[rd_ptr];
    assign pop.data  = data_mem[rd_ptr];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            pop_stall_q <= 1'b0;
        end
        else
        begin
            pop_stall_q <= pop.stall;
            if (do_push)
                wr_ptr <= wr_ptr + PTR_W'(1);
            if (do_pop)
                rd_ptr <= rd_ptr + PTR_W'(1);
            count <= count + {{PTR_W{1'b0}}, do_push} - {{PTR_W{1'b0}}, do_pop};
        end
    end

    // storage
    always_ff @(posedge clk)
    begin
        if (do_push)
        begin
            addr_mem[wr_ptr] <= push.addr;
            data_mem[wr_ptr] <= push.data;
        end
    end

endmodule

`default_nettype wire

// File: hw/line_writer.sv
`timescale 1ns/10ps
`default_nettype none

module line_writer
(
    input  logic                 clk,
    input  logic                 reset,
    wr_line_if.sink              pop,
    input  logic                 wr_almost_full,
    input  logic                 report,
    input  blur_pkg::t_line_addr status_addr,
    input  blur_pkg::t_count     cycle_cnt,
    input  blur_pkg::t_count     num_lines,
    output logic                 wr_req_valid,
    output blur_pkg::t_line_addr wr_req_addr,
    output blur_pkg::t_line_data wr_req_data,
    input  logic                 wr_rsp_valid,
    output blur_pkg::t_count     wr_req_cnt,
    output blur_pkg::t_count     wr_rsp_cnt
);

    // the status line is in flight, its ack is not a data ack
    logic status_pending;
    logic data_ack;

    assign pop.stall = wr_almost_full;
    assign data_ack  = wr_rsp_valid && !status_pending && (wr_rsp_cnt < num_lines);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_req_valid   <= 1'b0;
            wr_req_cnt     <= '0;
            wr_rsp_cnt     <= '0;
            status_pending <= 1'b0;
        end
        else
        begin
            wr_req_valid <= report || pop.valid;
            if (report)
            begin
                // the controller has already seen the final counts
                wr_req_cnt     <= '0;
                wr_rsp_cnt     <= '0;
                status_pending <= 1'b1;
            end
            else
            begin
                if (pop.valid)
                    wr_req_cnt <= wr_req_cnt + 1;
                if (data_ack)
                    wr_rsp_cnt <= wr_rsp_cnt + 1;
                else if (wr_rsp_valid)
                    status_pending <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (report)
        begin
            wr_req_addr <= status_addr;
            wr_req_data <= {wr_rsp_cnt, cycle_cnt};
        end
        else if (pop.valid)
        begin
            wr_req_addr <= pop.addr;
            wr_req_data <= pop.data;
        end
    end

endmodule

`default_nettype wire

// File: hw/blur_afu_top.sv
`timescale 1ns/10ps
`default_nettype none

module blur_afu_top
(
    input  logic                 clk,
    input  logic                 reset,
    // register port
    input  logic                 csr_wr_en,
    input  blur_pkg::t_csr_addr  csr_addr,
    input  blur_pkg::t_csr_data  csr_wr_data,
    output blur_pkg::t_csr_data  csr_rd_data,
    // host reads
    output logic                 rd_req_valid,
    output blur_pkg::t_line_addr rd_req_addr,
    output blur_pkg::t_line_tag  rd_req_tag,
    input  logic                 rd_almost_full,
    input  logic                 rd_rsp_valid,
    input  blur_pkg::t_line_tag  rd_rsp_tag,
    input  blur_pkg::t_line_data rd_rsp_data,
    // host writes
    output logic                 wr_req_valid,
    output blur_pkg::t_line_addr wr_req_addr,
    output blur_pkg::t_line_data wr_req_data,
    input  logic                 wr_almost_full,
    input  logic                 wr_rsp_valid
);
    import blur_pkg::*;

    logic       run_active;
    logic       report;
    logic       read_done;
    t_line_addr src_base;
    t_line_addr dst_base;
    t_line_addr status_addr;
    t_count     num_lines;
    t_count     cycle_cnt;
    t_count     read_idx;
    t_count     wr_req_cnt;
    t_count     wr_rsp_cnt;

    wr_line_if push ();
    wr_line_if pop ();

    afu_control u_control
    (
        .clk, .reset, .csr_wr_en, .csr_addr, .csr_wr_data, .csr_rd_data,
        .read_idx, .read_done, .wr_req_cnt, .wr_rsp_cnt, .run_active, .report,
        .src_base, .dst_base, .status_addr, .num_lines, .cycle_cnt
    );

    line_reader u_reader
    (
        .clk, .reset, .run_active, .src_base, .dst_base, .num_lines,
        .wr_rsp_valid, .rd_almost_full, .wr_almost_full,
        .rd_req_valid, .rd_req_addr, .rd_req_tag,
        .rd_rsp_valid, .rd_rsp_tag, .rd_rsp_data,
        .read_idx, .read_done, .push (push.source)
    );

    write_fifo u_fifo
    (
        .clk, .reset, .push (push.sink), .pop (pop.source)
    );

    line_writer u_writer
    (
        .clk, .reset, .pop (pop.sink), .wr_almost_full, .report, .status_addr,
        .cycle_cnt, .num_lines, .wr_req_valid, .wr_req_addr, .wr_req_data,
        .wr_rsp_valid, .wr_req_cnt, .wr_rsp_cnt
    );

endmodule

`default_nettype wire

// File: bench/blur_afu_assert.sv
`timescale 1ns/10ps
`default_nettype none

module blur_afu_assert
(
    input logic clk,
    input logic reset,
    input logic run_active,
    input logic report,
    input logic rd_almost_full,
    input logic wr_almost_full,
    input logic rd_req_valid,
    input logic wr_req_valid
);

    // the read pipeline sampled the level two cycles before the strobe
    a_read_paced: assert property (@(posedge clk) disable iff (reset)
        rd_req_valid |-> !$past(rd_almost_full, 2))
        else $error("read issued two cycles after rd_almost_full was high");

    // idle means neither active nor reporting
    a_idle_quiet: assert property (@(posedge clk) disable iff (reset)
        (!run_active && !report) |-> !rd_req_valid)
        else $error("read issued while the controller is idle");

    // the status line is exempt, it follows report directly
    a_write_paced: assert property (@(posedge clk) disable iff (reset)
        (wr_req_valid && !$past(report)) |-> !$past(wr_almost_full, 2))
        else $error("line written two cycles after wr_almost_full was high");

endmodule

bind blur_afu_top blur_afu_assert u_assert
(
    .clk            (clk),
    .reset          (reset),
    .run_active     (run_active),
    .report         (report),
    .rd_almost_full (rd_almost_full),
    .wr_almost_full (wr_almost_full),
    .rd_req_valid   (rd_req_valid),
    .wr_req_valid   (wr_req_valid)
);

`default_nettype wire

// File: bench/blur_afu_tb.sv
`timescale 1ns/10ps
`default_nettype none

module blur_afu_tb;
    import blur_pkg::*;

    logic       clk = 1'b0;
    logic       reset;
    logic       csr_wr_en;
    t_csr_addr  csr_addr;
    t_csr_data  csr_wr_data;
    t_csr_data  csr_rd_data;
    logic       rd_req_valid;
    t_line_addr rd_req_addr;
    t_line_tag  rd_req_tag;
    logic       rd_almost_full = 1'b0;
    logic       rd_rsp_valid = 1'b0;
    t_line_tag  rd_rsp_tag = '0;
    t_line_data rd_rsp_data = '0;
    logic       wr_req_valid;
    t_line_addr wr_req_addr;
    t_line_data wr_req_data;
    logic       wr_almost_full = 1'b0;
    logic       wr_rsp_valid = 1'b0;

    // host model state
    logic [31:0] rng = 32'h7f02_5e11;
    t_line_addr  rd_q_addr [$];
    t_line_tag   rd_q_tag [$];
    int          pending_acks = 0;

    // run bookkeeping
    t_line_addr  cur_src;
    t_line_addr  cur_dst;
    t_line_addr  cur_status;
    t_count      cur_lines;
    t_count      rd_issued = '0;
    bit          written [t_line_addr];
    int          lines_written = 0;
    int          status_writes = 0;
    t_line_data  status_data;
    bit          verdict_given = 1'b0;
    t_csr_data   rd;

    blur_afu_top DUT (.*);

    always #10 clk = ~clk;

    // ====================
    // reference model
    // ====================
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // source contents depend on the whole line address
    function automatic t_line_data src_line(input t_line_addr addr);
        return {addr * 32'h9e37_79b9, addr ^ 32'h5bd1_e995};
    endfunction

    function automatic t_line_data filter_line(input t_line_data line);
        t_line_data result;
        int         li;
        int         ri;
        int         sum;
        for (int i = 0; i < PIXELS_PER_LINE; i++)
        begin
            // edge pixels stand in for missing neighbours
            li  = (i == 0) ? 0 : i - 1;
            ri  = (i == PIXELS_PER_LINE - 1) ? i : i + 1;
            sum = int'(line[8 * li +: 8]) + 2 * int'(line[8 * i +: 8])
                  + int'(line[8 * ri +: 8]) + 2;
            result[8 * i +: 8] = t_pixel'(sum / 4);
        end
        return result;
    endfunction

    // ====================
    // checks
    // ====================
    task automatic abort_run();
        verdict_given = 1'b1;
        $display("Simulation failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_line(input string name, input t_line_data got, input t_line_data exp);
        if (got !== exp)
        begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_addr(input string name, input t_line_addr got, input t_line_addr exp);
        if (got !== exp)
        begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_tag(input string name, input t_line_tag got, input t_line_tag exp);
        if (got !== exp)
        begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_count(input string name, input t_count got, input t_count exp);
        if (got !== exp)
        begin
            $display("MISMATCH at %0t: %s got %0d expected %0d", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_state(input string name, input t_run_state got, input t_run_state exp);
        if (got !== exp)
        begin
            $display("MISMATCH at %0t: %s got %s expected %s", $time, name, got.name(),
                     exp.name());
            abort_run();
        end
    endtask

    // ====================
    // host memory model
    // ====================
    always @(negedge clk)
    begin
        int pick;
        if (!reset && rd_req_valid)
        begin
            rd_q_addr.push_back(rd_req_addr);
            rd_q_tag.push_back(rd_req_tag);
        end
        if (!reset && wr_req_valid)
            pending_acks++;
        rng = xorshift32(rng);
        rd_almost_full = (rng[2:0] == 3'd0);
        wr_almost_full = (rng[5:3] == 3'd0);
        // any pending read may answer next, so responses come back reordered
        rd_rsp_valid = 1'b0;
        if (rd_q_addr.size() > 0 && rng[7:6] != 2'b00)
        begin
            pick         = int'(rng[31:16]) % rd_q_addr.size();
            rd_rsp_valid = 1'b1;
            rd_rsp_tag   = rd_q_tag[pick];
            rd_rsp_data  = src_line(rd_q_addr[pick]);
            rd_q_addr.delete(pick);
            rd_q_tag.delete(pick);
        end
        wr_rsp_valid = 1'b0;
        if (pending_acks > 0 && rng[9:8] != 2'b00)
        begin
            wr_rsp_valid = 1'b1;
            pending_acks--;
        end
    end

    // compare process for host-side traffic
    always @(negedge clk)
    begin
        t_count idx;
        if (!reset && rd_req_valid)
        begin
            // reads leave in line order
            check_addr("rd_req_addr", rd_req_addr, cur_src + rd_issued);
            check_tag("rd_req_tag", rd_req_tag, t_line_tag'(rd_issued));
            rd_issued++;
        end
        if (!reset && wr_req_valid)
        begin
            if (wr_req_addr == cur_status)
            begin
                status_writes++;
                status_data = wr_req_data;
            end
            else
            begin
                idx = wr_req_addr - cur_dst;
                if (idx >= cur_lines)
                begin
                    $display("write to %h at %0t lies outside the destination lines",
                             wr_req_addr, $time);
                    abort_run();
                end
                if (written.exists(wr_req_addr))
                begin
                    $display("line at %h written a second time at %0t", wr_req_addr, $time);
                    abort_run();
                end
                written[wr_req_addr] = 1'b1;
                lines_written++;
                check_line("wr_req_data", wr_req_data, filter_line(src_line(cur_src + idx)));
            end
        end
    end

    // ====================
    // register access
    // ====================
    task automatic csr_write(input t_csr_addr addr, input t_csr_data data);
        @(negedge clk);
        csr_wr_en   = 1'b1;
        csr_addr    = addr;
        csr_wr_data = data;
        @(negedge clk);
        csr_wr_en   = 1'b0;
    endtask

    task automatic csr_read(input t_csr_addr addr, output t_csr_data data);
        @(negedge clk);
        csr_addr = addr;
        #5;
        data = csr_rd_data;
    endtask

    task automatic load_run(input t_line_addr src, input t_line_addr dst,
                            input t_line_addr status, input t_count lines);
        t_csr_data val;
        cur_src    = src;
        cur_dst    = dst;
        cur_status = status;
        cur_lines  = lines;
        csr_write(CSR_STATUS_ADDR, t_csr_data'(status));
        csr_write(CSR_SRC_ADDR, t_csr_data'(src));
        csr_write(CSR_DST_ADDR, t_csr_data'(dst));
        csr_write(CSR_NUM_LINES, t_csr_data'(lines));
        csr_read(CSR_STATUS_ADDR, val);
        check_addr("CSR_STATUS_ADDR", t_line_addr'(val), status);
        csr_read(CSR_SRC_ADDR, val);
        check_addr("CSR_SRC_ADDR", t_line_addr'(val), src);
        csr_read(CSR_DST_ADDR, val);
        check_addr("CSR_DST_ADDR", t_line_addr'(val), dst);
        csr_read(CSR_NUM_LINES, val);
        check_count("CSR_NUM_LINES", t_count'(val), lines);
    endtask

    task automatic run_and_check(input t_count lines);
        int        written_before;
        int        status_before;
        int        cycles;
        t_csr_data val;
        written_before = lines_written;
        status_before  = status_writes;
        cycles         = 0;
        rd_issued      = '0;
        csr_write(CSR_CTL, 64'd1);
        // done once every line and the status line are acknowledged
        while (lines_written - written_before != int'(lines)
               || status_writes == status_before || pending_acks != 0)
        begin
            @(posedge clk);
            cycles++;
            if (cycles > 8000)
            begin
                $display("timeout: run of %0d lines wrote only %0d lines", lines,
                         lines_written - written_before);
                abort_run();
            end
        end
        // room for a stray second status write
        repeat (10) @(posedge clk);
        check_count("status write count", t_count'(status_writes - status_before), 32'd1);
        check_count("status line high half", status_data[63:32], lines);
        if (status_data[31:0] == '0)
        begin
            $display("status line at %0t carries a zero cycle count", $time);
            abort_run();
        end
        check_count("reads issued", rd_issued, lines);
        csr_read(CSR_READ_IDX, val);
        check_count("CSR_READ_IDX", t_count'(val), lines);
        csr_read(CSR_STATE, val);
        check_state("CSR_STATE", t_run_state'(val[1:0]), RUN_IDLE);
    endtask

    // ====================
    // main sequence
    // ====================
    initial
    begin
        reset       = 1'b1;
        csr_wr_en   = 1'b0;
        csr_addr    = '0;
        csr_wr_data = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // start with a zero line count is ignored
        load_run(32'h0001_0000, 32'h0002_0000, 32'h0003_0000, 32'd0);
        csr_write(CSR_CTL, 64'd1);
        // the state is polled every cycle so a brief run is seen too
        repeat (50)
        begin
            csr_read(CSR_STATE, rd);
            check_state("CSR_STATE", t_run_state'(rd[1:0]), RUN_IDLE);
            if (rd_req_valid)
            begin
                $display("read request at %0t although the start was rejected", $time);
                abort_run();
            end
        end

        load_run(32'h0001_0000, 32'h0002_0000, 32'h0003_0000, 32'd40);
        run_and_check(32'd40);
        load_run(32'h0004_1000, 32'h0005_2000, 32'h0006_0040, 32'd25);
        run_and_check(32'd25);

        if (rd_q_addr.size() == 0 && pending_acks == 0)
        begin
            verdict_given = 1'b1;
            $display("Simulation passed");
            $finish;
        end
        else
        begin
            $display("host model still holds requests after the last run");
            abort_run();
        end
    end

    // a failed assertion ends the run without a verdict
    final
    begin
        if (!verdict_given)
            $display("Simulation failed");
    end

endmodule

`default_nettype wire

// File: build.f
hw/blur_pkg.sv
hw/wr_line_if.sv
hw/gaussian_row_filter.sv
hw/afu_control.sv
hw/line_reader.sv
hw/write_fifo.sv
hw/line_writer.sv
hw/blur_afu_top.sv
bench/blur_afu_assert.sv
bench/blur_afu_tb.sv

// File: Makefile
# Verilator flow for the blur AFU testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and search the log for the pass line"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/10ps \
		--top-module blur_afu_tb -f build.f -Mdir obj_dir
	./obj_dir/Vblur_afu_tb | tee sim.log
	grep -q "^Simulation passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
